//--- rtl/awp_defs.svh
`ifndef AWP_DEFS_SVH
`define AWP_DEFS_SVH

//////////////////////////////////////////////////////////////////////
// Transaction field widths
//////////////////////////////////////////////////////////////////////

// Meta byte carried with every transaction
`define AWP_META_WIDTH 8

// Payload word, decoded as config or pixel
`define AWP_PYLD_WIDTH 32

//////////////////////////////////////////////////////////////////////
// Quad chain geometry
//////////////////////////////////////////////////////////////////////

`define AWP_NUM_QUADS 4

// One pixel lane per quad, weights share the width
`define AWP_LANE_WIDTH 8

// Cascade sum, wraps modulo 2^16
`define AWP_SUM_WIDTH 16

// Ingress FIFO entries
`define AWP_IN_FIFO_DEPTH 4

`endif

//--- rtl/awp_pkg.sv
`include "awp_defs.svh"

package awp_pkg;

    //////////////////////////////////////////////////////////////////////
    // Transaction layout
    //////////////////////////////////////////////////////////////////////

    // Kind bit set for config, clear for pixel
    typedef struct packed {
        logic       kind;
        logic [6:0] tag;
    } awp_meta_t;

    // Lane k feeds quad k, lane 0 in the low byte
    typedef struct packed {
        logic [`AWP_NUM_QUADS-1:0][`AWP_LANE_WIDTH-1:0] lane;
    } awp_pixel_pyld_t;

    // Weight load aimed at a single quad
    typedef struct packed {
        logic [`AWP_PYLD_WIDTH-$clog2(`AWP_NUM_QUADS)-`AWP_LANE_WIDTH-1:0] rsvd;
        logic [$clog2(`AWP_NUM_QUADS)-1:0]                                quad_sel;
        logic [`AWP_LANE_WIDTH-1:0]                                       weight;
    } awp_cfg_pyld_t;

    // Same payload word, two views picked by meta.kind
    typedef union packed {
        awp_pixel_pyld_t pixel;
        awp_cfg_pyld_t   cfg;
    } awp_pyld_u;

    typedef struct packed {
        awp_meta_t meta;
        awp_pyld_u pyld;
    } awp_trans_t;

    //////////////////////////////////////////////////////////////////////
    // Cascade and result
    //////////////////////////////////////////////////////////////////////

    // Item moving down the quad chain with its running sum
    typedef struct packed {
        awp_trans_t                trans;
        logic [`AWP_SUM_WIDTH-1:0] sum;
    } awp_stage_t;

    typedef struct packed {
        awp_meta_t                 meta;
        logic [`AWP_SUM_WIDTH-1:0] sum;
    } awp_result_t;

    //////////////////////////////////////////////////////////////////////
    // Wishbone request bundles
    //////////////////////////////////////////////////////////////////////

    typedef struct packed {
        logic                                         cyc;
        logic                                         stb;
        logic                                         we;
        logic [`AWP_META_WIDTH+`AWP_PYLD_WIDTH-1:0]   dat;
    } awp_wb_in_req_t;

    typedef struct packed {
        logic                                         cyc;
        logic                                         stb;
        logic                                         we;
        logic [`AWP_META_WIDTH+`AWP_SUM_WIDTH-1:0]    dat;
    } awp_wb_out_req_t;

endpackage

//--- rtl/awp_ingress.sv
`timescale 1ns/1ps

`include "awp_defs.svh"

module awp_ingress import awp_pkg::*; (
    input  logic           clk_intf,
    input  logic           rst_n,
    input  awp_wb_in_req_t wb_in_req,
    output logic           wb_in_ack,
    output logic           stage_valid,
    input  logic           stage_ready,
    output awp_stage_t     stage
);

    localparam int DEPTH = `AWP_IN_FIFO_DEPTH;
    localparam int PTR_W = $clog2(DEPTH);
    localparam int CNT_W = $clog2(DEPTH + 1);

    //////////////////////////////////////////////////////////////////////
    // Declarations
    //////////////////////////////////////////////////////////////////////

    // FIFO storage, head read straight out
    awp_trans_t       fifo_mem [DEPTH];
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;

    logic             bus_req;
    logic             has_room;
    logic             push;
    logic             pop;
    logic             ack_next;

    //////////////////////////////////////////////////////////////////////
    // Wishbone slave side
    //////////////////////////////////////////////////////////////////////

    // New request only while ack is low, else same cycle seen twice
    assign bus_req  = wb_in_req.cyc && wb_in_req.stb && !wb_in_ack;

    // Slot freed by a pop on this edge counts as room
    assign has_room = (count != CNT_W'(DEPTH)) || pop;

    // Writes into FIFO
    assign push     = bus_req && wb_in_req.we && has_room;

    // Reads are acked with no data effect
    assign ack_next = bus_req && (!wb_in_req.we || has_room);

    always_ff @(posedge clk_intf) begin
        if (!rst_n) begin
            wb_in_ack <= 1'b0;
        end else begin
            // Single cycle pulse, host drops stb after it
            wb_in_ack <= ack_next;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // FWFT FIFO
    //////////////////////////////////////////////////////////////////////

    assign pop = stage_valid && stage_ready;

    always_ff @(posedge clk_intf) begin
        if (push) begin
            fifo_mem[wr_ptr] <= awp_trans_t'(wb_in_req.dat);
        end
    end

    always_ff @(posedge clk_intf) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                // Wrap at last entry
                if (wr_ptr == PTR_W'(DEPTH - 1)) begin
                    wr_ptr <= '0;
                end else begin
                    wr_ptr <= wr_ptr + 1'b1;
                end
            end
            if (pop) begin
                if (rd_ptr == PTR_W'(DEPTH - 1)) begin
                    rd_ptr <= '0;
                end else begin
                    rd_ptr <= rd_ptr + 1'b1;
                end
            end
            // Occupancy
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    //////////////////////////////////////////////////////////////////////
    // First cascade stage
    //////////////////////////////////////////////////////////////////////

    // Head of FIFO is the chain input, cascade starts at zero
    assign stage_valid = (count != '0);
    assign stage.trans = fifo_mem[rd_ptr];
    assign stage.sum   = '0;

endmodule

//--- rtl/awp_quad.sv
`timescale 1ns/1ps

`include "awp_defs.svh"

module awp_quad import awp_pkg::*; #(
    parameter int QUAD_INDEX = 0
) (
    input  logic       clk_intf,
    input  logic       rst_n,
    input  logic       in_valid,
    output logic       in_ready,
    input  awp_stage_t in_stage,
    output logic       out_valid,
    input  logic       out_ready,
    output awp_stage_t out_stage
);

    localparam int SEL_W = $clog2(`AWP_NUM_QUADS);

    // Config quad select value that addresses this quad
    localparam logic [SEL_W-1:0] QUAD_SEL = QUAD_INDEX[SEL_W-1:0];

    //////////////////////////////////////////////////////////////////////
    // Declarations
    //////////////////////////////////////////////////////////////////////

    logic [`AWP_LANE_WIDTH-1:0] weight_q;

    // Output register stage
    awp_stage_t                 out_stage_q;
    logic                       out_valid_q;

    logic                       in_xfer;
    logic                       is_cfg;
    logic                       cfg_hit;
    logic [`AWP_LANE_WIDTH-1:0] pixel_lane;
    logic [`AWP_SUM_WIDTH-1:0]  product;
    awp_stage_t                 next_stage;

    //////////////////////////////////////////////////////////////////////
    // Handshake
    //////////////////////////////////////////////////////////////////////

    // Take a new item if empty or draining this cycle
    assign in_ready = !out_valid_q || out_ready;
    assign in_xfer  = in_valid && in_ready;

    //////////////////////////////////////////////////////////////////////
    // Payload decode and multiply-add
    //////////////////////////////////////////////////////////////////////

    assign is_cfg     = in_stage.trans.meta.kind;

    // Config view of the payload
    assign cfg_hit    = is_cfg && (in_stage.trans.pyld.cfg.quad_sel == QUAD_SEL);

    // Pixel view, own lane only
    assign pixel_lane = in_stage.trans.pyld.pixel.lane[QUAD_INDEX];

    // Operands widened to sum width before the multiply
    assign product    = weight_q * pixel_lane;

    always_comb begin
        next_stage = in_stage;
        // Config items pass untouched
        if (!is_cfg) begin
            next_stage.sum = in_stage.sum + product;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_intf) begin
        if (!rst_n) begin
            weight_q    <= '0;
            out_valid_q <= 1'b0;
        end else begin
            if (in_xfer && cfg_hit) begin
                weight_q <= in_stage.trans.pyld.cfg.weight;
            end
            if (in_xfer) begin
                out_valid_q <= 1'b1;
            end else if (out_ready) begin
                out_valid_q <= 1'b0;
            end
        end
    end

    // Cascade payload, valid flag qualifies it
    always_ff @(posedge clk_intf) begin
        if (in_xfer) begin
            out_stage_q <= next_stage;
        end
    end

    assign out_valid = out_valid_q;
    assign out_stage = out_stage_q;

endmodule

//--- rtl/awp_egress.sv
`timescale 1ns/1ps

`include "awp_defs.svh"

module awp_egress import awp_pkg::*; (
    input  logic            clk_intf,
    input  logic            rst_n,
    input  logic            in_valid,
    output logic            in_ready,
    input  awp_stage_t      in_stage,
    output awp_wb_out_req_t wb_out_req,
    input  logic            wb_out_ack
);

    //////////////////////////////////////////////////////////////////////
    // Declarations
    //////////////////////////////////////////////////////////////////////

    // Result holding register and its occupancy
    awp_result_t res_q;
    logic        busy_q;

    logic        in_xfer;
    logic        in_pixel;
    logic        load;
    logic        bus_done;
    awp_result_t res_next;

    //////////////////////////////////////////////////////////////////////
    // Input side
    //////////////////////////////////////////////////////////////////////

    // Bus cycle ends on this edge
    assign bus_done = busy_q && wb_out_ack;

    // Free, or freed by the ack this cycle
    assign in_ready = !busy_q || bus_done;
    assign in_xfer  = in_valid && in_ready;

    assign in_pixel = !in_stage.trans.meta.kind;

    // Config items are consumed here and go no further
    assign load     = in_xfer && in_pixel;

    always_comb begin
        res_next.meta = in_stage.trans.meta;
        res_next.sum  = in_stage.sum;
    end

    //////////////////////////////////////////////////////////////////////
    // Result register
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk_intf) begin
        if (!rst_n) begin
            busy_q <= 1'b0;
        end else begin
            if (load) begin
                busy_q <= 1'b1;
            end else if (bus_done) begin
                busy_q <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_intf) begin
        if (load) begin
            res_q <= res_next;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Wishbone classic master
    //////////////////////////////////////////////////////////////////////

    // Cyc, stb and we together for the whole write
    // Back to back results keep stb high, dat moves after the ack
    assign wb_out_req.cyc = busy_q;
    assign wb_out_req.stb = busy_q;
    assign wb_out_req.we  = busy_q;
    assign wb_out_req.dat = res_q;

endmodule

//--- rtl/cnn_layer_accel_awp.sv
`timescale 1ns/1ps

`include "awp_defs.svh"

module cnn_layer_accel_awp import awp_pkg::*; (
    input  logic            clk_intf,
    input  logic            rst_n,
    input  awp_wb_in_req_t  wb_in_req,
    output logic            wb_in_ack,
    output awp_wb_out_req_t wb_out_req,
    input  logic            wb_out_ack
);

    //////////////////////////////////////////////////////////////////////
    // Stage links
    //////////////////////////////////////////////////////////////////////

    // Link 0 from ingress, link k+1 out of quad k, last into egress
    logic [`AWP_NUM_QUADS:0] stage_valid;
    logic [`AWP_NUM_QUADS:0] stage_ready;
    awp_stage_t              stage [`AWP_NUM_QUADS+1];

    //////////////////////////////////////////////////////////////////////
    // Ingress
    //////////////////////////////////////////////////////////////////////

    awp_ingress u_ingress (
        .clk_intf    (clk_intf),
        .rst_n       (rst_n),
        .wb_in_req   (wb_in_req),
        .wb_in_ack   (wb_in_ack),
        .stage_valid (stage_valid[0]),
        .stage_ready (stage_ready[0]),
        .stage       (stage[0])
    );

    // Quad chain
    for (genvar gi = 0; gi < `AWP_NUM_QUADS; gi++) begin : g_quad
        awp_quad #(
            .QUAD_INDEX (gi)
        ) u_quad (
            .clk_intf  (clk_intf),
            .rst_n     (rst_n),
            .in_valid  (stage_valid[gi]),
            .in_ready  (stage_ready[gi]),
            .in_stage  (stage[gi]),
            .out_valid (stage_valid[gi+1]),
            .out_ready (stage_ready[gi+1]),
            .out_stage (stage[gi+1])
        );
    end

    //////////////////////////////////////////////////////////////////////
    // Egress
    //////////////////////////////////////////////////////////////////////

    awp_egress u_egress (
        .clk_intf   (clk_intf),
        .rst_n      (rst_n),
        .in_valid   (stage_valid[`AWP_NUM_QUADS]),
        .in_ready   (stage_ready[`AWP_NUM_QUADS]),
        .in_stage   (stage[`AWP_NUM_QUADS]),
        .wb_out_req (wb_out_req),
        .wb_out_ack (wb_out_ack)
    );

endmodule

//--- verification/awp_props.sv
`timescale 1ns/1ps

module awp_props import awp_pkg::*; (
    input logic            clk_intf,
    input logic            rst_n,
    input awp_wb_in_req_t  wb_in_req,
    input logic            wb_in_ack,
    input awp_wb_out_req_t wb_out_req,
    input logic            wb_out_ack
);

    //////////////////////////////////////////////////////////////////////
    // Ingress slave port
    //////////////////////////////////////////////////////////////////////

    // Ack answers a request seen on the previous edge
    a_in_ack_after_req: assert property (
        @(posedge clk_intf) disable iff (!rst_n)
        wb_in_ack |-> $past(wb_in_req.cyc && wb_in_req.stb)
    ) else $error("wb_in_ack high without cyc and stb on the previous edge");

    //////////////////////////////////////////////////////////////////////
    // Egress master port
    //////////////////////////////////////////////////////////////////////

    a_out_stb_in_cyc: assert property (
        @(posedge clk_intf) disable iff (!rst_n)
        wb_out_req.stb |-> wb_out_req.cyc
    ) else $error("wb_out_req.stb high outside a bus cycle");

    // Waiting write holds stb and data until the sink acks
    a_out_hold: assert property (
        @(posedge clk_intf) disable iff (!rst_n)
        (wb_out_req.stb && !wb_out_ack) |=> (wb_out_req.stb && $stable(wb_out_req.dat))
    ) else $error("wb_out_req stb or dat changed before ack");

endmodule

bind cnn_layer_accel_awp awp_props u_props (
    .clk_intf   (clk_intf),
    .rst_n      (rst_n),
    .wb_in_req  (wb_in_req),
    .wb_in_ack  (wb_in_ack),
    .wb_out_req (wb_out_req),
    .wb_out_ack (wb_out_ack)
);

//--- verification/awp_tb.sv
`timescale 1ns/1ps

`include "awp_defs.svh"

module awp_tb import awp_pkg::*; ();

    // Run length bound, at most this many host writes
    localparam int NUM_TRANS      = 300;
    localparam int TIMEOUT_CYCLES = NUM_TRANS * 24 + 200;
    localparam int WRITE_WAIT     = 200;

    // Sink behaviour
    localparam int SINK_FREE   = 0;
    localparam int SINK_RANDOM = 1;
    localparam int SINK_STALL  = 2;

    logic            clk_intf = 1'b0;
    logic            rst_n;
    awp_wb_in_req_t  wb_in_req;
    logic            wb_in_ack;
    awp_wb_out_req_t wb_out_req;
    logic            wb_out_ack;

    // Reference model state
    logic [`AWP_LANE_WIDTH-1:0] weights [`AWP_NUM_QUADS];
    awp_result_t                exp_q [$];

    // Most recent result taken by the sink
    awp_result_t                last_out = '0;

    int          mismatch_count = 0;
    int          fail_count     = 0;
    int          cycle_count    = 0;
    int          sink_mode      = SINK_FREE;
    logic [31:0] stim_seed      = 32'd23584;
    // Sink gets its own stream, so its choices never shift the stimulus
    logic [31:0] sink_seed      = ~32'd23584;

    cnn_layer_accel_awp dut0 (
        .clk_intf   (clk_intf),
        .rst_n      (rst_n),
        .wb_in_req  (wb_in_req),
        .wb_in_ack  (wb_in_ack),
        .wb_out_req (wb_out_req),
        .wb_out_ack (wb_out_ack)
    );

    initial begin : clock
        forever #50 clk_intf = ~clk_intf;
    end

    //////////////////////////////////////////////////////////////////////
    // Random numbers and transaction builders
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1103515245 + 32'd12345;
    endfunction

    // Middle bits, low LCG bits repeat too soon
    function automatic logic [7:0] rand_byte();
        stim_seed = lcg_step(stim_seed);
        return stim_seed[23:16];
    endfunction

    function automatic logic [31:0] rand_lanes();
        logic [31:0] w;
        for (int k = 0; k < `AWP_NUM_QUADS; k++) begin
            w[8*k +: 8] = rand_byte();
        end
        return w;
    endfunction

    function automatic awp_trans_t make_cfg(input logic [1:0] sel, input logic [7:0] w);
        awp_trans_t t;
        logic [7:0] b;
        b                  = rand_byte();
        t                  = '0;
        t.meta.kind        = 1'b1;
        t.meta.tag         = b[6:0];
        t.pyld.cfg.quad_sel = sel;
        t.pyld.cfg.weight  = w;
        return t;
    endfunction

    function automatic awp_trans_t make_pixel(input logic [31:0] lanes);
        awp_trans_t t;
        logic [7:0] b;
        b                    = rand_byte();
        t.meta.kind          = 1'b0;
        t.meta.tag           = b[6:0];
        t.pyld.pixel.lane    = lanes;
        return t;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Reference model and checks
    //////////////////////////////////////////////////////////////////////

    // Applied in host write order, the order the chain sees items
    task automatic model_accept(input awp_trans_t t);
        awp_result_t r;
        logic [15:0] acc;
        if (t.meta.kind) begin
            weights[t.pyld.cfg.quad_sel] = t.pyld.cfg.weight;
        end else begin
            acc = '0;
            for (int k = 0; k < `AWP_NUM_QUADS; k++) begin
                acc = acc + 16'(weights[k]) * 16'(t.pyld.pixel.lane[k]);
            end
            r.meta = t.meta;
            r.sum  = acc;
            exp_q.push_back(r);
        end
    endtask

    task automatic compare_result(input string name, input awp_result_t got,
                                  input awp_result_t exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_ctrl(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            mismatch_count++;
            $display("MISMATCH at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // Host and sink
    //////////////////////////////////////////////////////////////////////

    // Called on a falling edge, returns on one, request held if not acked
    task automatic host_try_write(input awp_trans_t t, input int max_wait, output bit acked);
        acked         = 1'b0;
        wb_in_req.cyc = 1'b1;
        wb_in_req.stb = 1'b1;
        wb_in_req.we  = 1'b1;
        wb_in_req.dat = t;
        for (int i = 0; i < max_wait && !acked; i++) begin
            @(negedge clk_intf);
            acked = wb_in_ack;
        end
        if (acked) begin
            wb_in_req.cyc = 1'b0;
            wb_in_req.stb = 1'b0;
            wb_in_req.we  = 1'b0;
            model_accept(t);
        end
    endtask

    task automatic host_write(input awp_trans_t t);
        bit acked;
        host_try_write(t, WRITE_WAIT, acked);
        if (!acked) begin
            fail_count++;
            $display("Host write %h was not acknowledged within %0d cycles", t, WRITE_WAIT);
        end
    endtask

    // One config in four, rest pixels
    task automatic write_random();
        logic [7:0] b;
        b = rand_byte();
        if (b[7:6] == 2'b00) begin
            host_write(make_cfg(b[1:0], rand_byte()));
        end else begin
            host_write(make_pixel(rand_lanes()));
        end
    endtask

    // Mode changes on the rising edge, away from the sink's decisions
    task automatic set_sink_mode(input int mode);
        @(posedge clk_intf);
        sink_mode = mode;
        @(negedge clk_intf);
    endtask

    task automatic drain();
        while (exp_q.size() != 0) begin
            @(negedge clk_intf);
        end
        repeat (10) @(negedge clk_intf);
    endtask

    task automatic check_output();
        awp_result_t got;
        got      = awp_result_t'(wb_out_req.dat);
        last_out = got;
        compare_ctrl("wb_out_req.cyc", wb_out_req.cyc, 1'b1);
        compare_ctrl("wb_out_req.we", wb_out_req.we, 1'b1);
        if (exp_q.size() == 0) begin
            fail_count++;
            $display("Result %h at %0t arrived with no pixel write pending", got, $time);
        end else begin
            compare_result("wb_out_req.dat", got, exp_q.pop_front());
        end
    endtask

    // Ack decided on the falling edge, transfer lands on the next rising edge
    initial begin : sink
        bit take;
        wb_out_ack = 1'b0;
        forever begin
            @(negedge clk_intf);
            sink_seed = lcg_step(sink_seed);
            case (sink_mode)
                SINK_FREE:   take = 1'b1;
                SINK_RANDOM: take = sink_seed[20];
                default:     take = 1'b0;
            endcase
            wb_out_ack = take && wb_out_req.stb;
            if (wb_out_ack) begin
                check_output();
            end
        end
    end

    initial begin : watchdog
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk_intf);
            cycle_count++;
        end
        $display("Timeout after %0d cycles with %0d results outstanding",
                 cycle_count, exp_q.size());
        $display("Finished with errors");
        $finish;
    end

    //////////////////////////////////////////////////////////////////////
    // Test sequence
    //////////////////////////////////////////////////////////////////////

    initial begin : main
        awp_trans_t t;
        bit         acked;
        bit         stalled;
        wb_in_req = '0;
        rst_n     = 1'b0;
        weights   = '{default: '0};
        repeat (2) @(negedge clk_intf);
        rst_n = 1'b1;

        // Idle bus after reset, zero weights give a zero sum
        @(negedge clk_intf);
        compare_ctrl("wb_in_ack", wb_in_ack, 1'b0);
        compare_ctrl("wb_out_req.cyc", wb_out_req.cyc, 1'b0);
        compare_ctrl("wb_out_req.stb", wb_out_req.stb, 1'b0);
        t = make_pixel(rand_lanes());
        host_write(t);
        drain();
        compare_result("wb_out_req.dat", last_out, awp_result_t'{t.meta, 16'd0});

        // Weights in every quad, then pixels
        for (int q = 0; q < `AWP_NUM_QUADS; q++) begin
            host_write(make_cfg(2'(q), rand_byte()));
        end
        repeat (20) host_write(make_pixel(rand_lanes()));
        drain();

        // Mixed stream
        repeat (120) write_random();
        drain();

        // Sink acks at random
        set_sink_mode(SINK_RANDOM);
        repeat (80) write_random();
        drain();

        // Sink stalled until the ingress refuses a write
        set_sink_mode(SINK_STALL);
        stalled = 1'b0;
        for (int i = 0; i < 16 && !stalled; i++) begin
            t = make_pixel(rand_lanes());
            host_try_write(t, 30, acked);
            stalled = !acked;
        end
        if (!stalled) begin
            fail_count++;
            $display("Ingress kept acknowledging writes while the sink was stalled");
        end
        set_sink_mode(SINK_FREE);
        // Held request goes through once the sink resumes
        if (stalled) begin
            host_write(t);
        end
        repeat (4) host_write(make_pixel(rand_lanes()));
        drain();

        // Full scale weights and lanes, sum wraps
        for (int q = 0; q < `AWP_NUM_QUADS; q++) begin
            host_write(make_cfg(2'(q), 8'hff));
        end
        repeat (4) begin
            t = make_pixel(32'hffff_ffff);
            host_write(t);
            drain();
            compare_result("wb_out_req.dat", last_out, awp_result_t'{t.meta, 16'd63492});
        end

        if (exp_q.size() != 0) begin
            fail_count++;
            $display("%0d expected results never left the egress", exp_q.size());
        end
        $display("Error counts: %0d mismatches, %0d other failures",
                 mismatch_count, fail_count);
        if (mismatch_count == 0 && fail_count == 0) begin
            $display("Finished with no errors");
        end else begin
            $display("Finished with errors");
        end
        $finish;
    end

endmodule

//--- cnn_layer_accel_awp.f
+incdir+rtl
rtl/awp_pkg.sv
rtl/awp_ingress.sv
rtl/awp_quad.sv
rtl/awp_egress.sv
rtl/cnn_layer_accel_awp.sv
verification/awp_props.sv
verification/awp_tb.sv

//--- Makefile
SIM      = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = awp_tb
FILELIST = cnn_layer_accel_awp.f
OBJ_DIR  = obj_dir
PASS_MSG = Finished with no errors

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check for the pass line"
	@echo "  clean  remove the Verilator build directory"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)
	@out=$$(./$(OBJ_DIR)/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
